/* hw/issue_pkg.sv */
/*
 * Shared types for the integer issue and read-operands stage.
 * Integer registers only; register 0 is hardwired to zero.
 * Enum encodings are fixed here and must match the decoder.
 */
package issue_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned REG_ADDR_SIZE = 5;
    localparam int unsigned NR_REGS       = 32;
    localparam int unsigned TRANS_ID_BITS = 3;

    typedef logic [REG_ADDR_SIZE-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]          xlen_t;

    // target functional unit, NONE means nothing to issue
    typedef enum logic [2:0] {
        NONE, ALU, CTRL_FLOW, LOAD, STORE, CSR
    } fu_t;

    // operation carried to the unit
    typedef enum logic [3:0] {
        ADD, SUB, AND_OP, OR_OP, BEQ, JAL, LW, SW, CSRRW
    } fu_op_t;

    // ------------------------------------------------------------------------
    // structs
    // ------------------------------------------------------------------------
    // one decoded instruction from the scoreboard
    typedef struct packed {
        fu_t                      fu;
        fu_op_t                   op;
        reg_addr_t                rs1;
        reg_addr_t                rs2;
        reg_addr_t                rd;
        xlen_t                    result;    // immediate
        logic                     use_imm;
        logic                     use_pc;
        logic                     use_zimm;
        xlen_t                    pc;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic                     ex_valid;  // exception already raised
    } issue_entry_t;

    // operands toward execute
    typedef struct packed {
        fu_t                      fu;
        fu_op_t                   op;
        xlen_t                    operand_a;
        xlen_t                    operand_b;
        xlen_t                    imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // one write-back port from commit
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        xlen_t     wdata;
    } commit_port_t;

endpackage

/* hw/issue_hazard_check.sv */
/*
 * Hazard checker of the issue stage, purely combinational.
 * A source clobbered by CSR is never forwarded and stalls the entry.
 * Exception entries and NONE entries are acknowledged without checks.
 */
module issue_hazard_check #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  issue_pkg::issue_entry_t                        issue_instr_i,
    input  logic                                           issue_valid_i,
    input  issue_pkg::fu_t [issue_pkg::NR_REGS-1:0]        rd_clobber_i,
    input  logic                                           rs1_valid_i,
    input  logic                                           rs2_valid_i,
    input  logic                                           flu_ready_i,
    input  logic                                           lsu_ready_i,
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0]  commit_i,
    output issue_pkg::reg_addr_t                           rs1_o,
    output issue_pkg::reg_addr_t                           rs2_o,
    output logic                                           forward_rs1_o,
    output logic                                           forward_rs2_o,
    output logic                                           issue_ack_o
);
    import issue_pkg::*;

    logic fu_busy;
    logic stall;

    // scoreboard lookup uses the source indices as they are
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    // busy flag of the unit this entry targets
    always_comb begin
        case (issue_instr_i.fu)
            ALU, CTRL_FLOW, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:         fu_busy = ~lsu_ready_i;
            default:             fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // source operands: forward when ready, else stall
    // ------------------------------------------------------------------------
    always_comb begin
        stall         = 1'b0;
        forward_rs1_o = 1'b0;
        forward_rs2_o = 1'b0;
        // zimm in rs1 is an immediate, no dependency
        if (!issue_instr_i.use_zimm && rd_clobber_i[issue_instr_i.rs1] != NONE) begin
            // CSR results only come back through the register file
            if (rs1_valid_i && rd_clobber_i[issue_instr_i.rs1] != CSR) begin
                forward_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rd_clobber_i[issue_instr_i.rs2] != NONE) begin
            if (rs2_valid_i && rd_clobber_i[issue_instr_i.rs2] != CSR) begin
                forward_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // acknowledge
    // ------------------------------------------------------------------------
    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy) begin
                // WAW check: rd free, or freed by a commit this very cycle
                if (rd_clobber_i[issue_instr_i.rd] == NONE) begin
                    issue_ack_o = 1'b1;
                end
                for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
                    if (commit_i[i].we && commit_i[i].waddr == issue_instr_i.rd) begin
                        issue_ack_o = 1'b1;
                    end
                end
            end
            // nothing to execute, let it pass
            if (issue_instr_i.ex_valid || issue_instr_i.fu == NONE) begin
                issue_ack_o = 1'b1;
            end
        end
    end

    // an undefined unit code would be acked and then reach no unit
    always_comb begin
        a_valid_fu_legal: assert (!issue_valid_i ||
                                  issue_instr_i.fu inside {NONE, ALU, CTRL_FLOW, LOAD, STORE, CSR})
            else $error("valid entry targets an undefined unit");
    end

endmodule

/* hw/issue_regfile.sv */
/*
 * Integer register file with two combinational read ports.
 * Writes land on the clock edge and are seen the next cycle.
 * Register 0 reads zero; the highest port wins on equal indices.
 */
module issue_regfile #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  issue_pkg::reg_addr_t                           raddr_a_i,
    input  issue_pkg::reg_addr_t                           raddr_b_i,
    output issue_pkg::xlen_t                               rdata_a_o,
    output issue_pkg::xlen_t                               rdata_b_o,
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0]  commit_i
);
    import issue_pkg::*;

    // index 0 has no storage
    xlen_t [NR_REGS-1:1] regs_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            regs_q <= '0;
        end else begin
            // ascending loop, so the later port overrides
            for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                if (commit_i[p].we && commit_i[p].waddr != '0) begin
                    regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // zero register on the read side
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

    // ------------------------------------------------------------------------
    // commit must not write one register from two ports at once
    // ------------------------------------------------------------------------
    for (genvar p = 0; p < NR_COMMIT_PORTS; p++) begin : gen_port_chk
        for (genvar q = p + 1; q < NR_COMMIT_PORTS; q++) begin : gen_pair_chk
            a_no_dup_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
                !(commit_i[p].we && commit_i[q].we &&
                  commit_i[p].waddr == commit_i[q].waddr && commit_i[p].waddr != '0))
                else $error("two commit ports write the same register");
        end
    end

endmodule

/* hw/issue_operand_stage.sv */
/*
 * Operand select and ID/EX register of the issue stage.
 * fu_data_o loads every cycle; it is meaningful only with a unit valid.
 * Unit valids rise one cycle after issue and are cleared by flush.
 */
module issue_operand_stage (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  issue_pkg::issue_entry_t issue_instr_i,
    input  logic                    issue_valid_i,
    input  logic                    issue_ack_i,
    input  logic                    flush_i,
    input  logic                    forward_rs1_i,
    input  logic                    forward_rs2_i,
    input  issue_pkg::xlen_t        rs1_i,
    input  issue_pkg::xlen_t        rs2_i,
    input  issue_pkg::xlen_t        rf_a_i,
    input  issue_pkg::xlen_t        rf_b_i,
    output issue_pkg::fu_data_t     fu_data_o,
    output logic                    alu_valid_o,
    output logic                    branch_valid_o,
    output logic                    lsu_valid_o,
    output logic                    csr_valid_o
);
    import issue_pkg::*;

    fu_data_t fu_data_d;
    fu_data_t fu_data_q;
    logic     issue;

    // ------------------------------------------------------------------------
    // operand mux
    // ------------------------------------------------------------------------
    always_comb begin
        fu_data_d.fu        = issue_instr_i.fu;
        fu_data_d.op        = issue_instr_i.op;
        fu_data_d.imm       = issue_instr_i.result;
        fu_data_d.trans_id  = issue_instr_i.trans_id;
        // lowest priority first, later ones override
        fu_data_d.operand_a = forward_rs1_i ? rs1_i : rf_a_i;
        fu_data_d.operand_b = forward_rs2_i ? rs2_i : rf_b_i;
        if (issue_instr_i.use_pc) begin
            fu_data_d.operand_a = issue_instr_i.pc;
        end
        // zimm sits in the rs1 field
        if (issue_instr_i.use_zimm) begin
            fu_data_d.operand_a = {{(XLEN-REG_ADDR_SIZE){1'b0}}, issue_instr_i.rs1};
        end
        // stores and branches keep rs2 in operand b, the immediate rides in imm
        if (issue_instr_i.use_imm && issue_instr_i.fu != STORE &&
            issue_instr_i.fu != CTRL_FLOW) begin
            fu_data_d.operand_b = issue_instr_i.result;
        end
    end

    // ------------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_q <= '0;
        end else begin
            fu_data_q <= fu_data_d;
        end
    end

    assign fu_data_o = fu_data_q;

    // exception entries are acked but never reach a unit
    assign issue = issue_valid_i && issue_ack_i && !issue_instr_i.ex_valid;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            csr_valid_o    <= 1'b0;
        end else begin
            alu_valid_o    <= issue && !flush_i && issue_instr_i.fu == ALU;
            branch_valid_o <= issue && !flush_i && issue_instr_i.fu == CTRL_FLOW;
            lsu_valid_o    <= issue && !flush_i &&
                              (issue_instr_i.fu == LOAD || issue_instr_i.fu == STORE);
            csr_valid_o    <= issue && !flush_i && issue_instr_i.fu == CSR;
        end
    end

    // an entry that was offered and not taken stays on the input unchanged
    a_hold_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_valid_i && !issue_ack_i && !flush_i |=>
            issue_valid_i && $stable(issue_instr_i))
        else $error("entry changed before it was acknowledged");

endmodule

/* hw/issue_read_operands.sv */
/*
 * Issue and read-operands stage, top level.
 * Entry handshake is valid/ack, ack is combinational in the same cycle.
 * Back-pressure only through the unit ready inputs.
 */
module issue_read_operands #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic                                           flush_i,
    // entry from the scoreboard
    input  issue_pkg::issue_entry_t                        issue_instr_i,
    input  logic                                           issue_valid_i,
    output logic                                           issue_ack_o,
    // clobber table and operand lookup
    input  issue_pkg::fu_t [issue_pkg::NR_REGS-1:0]        rd_clobber_i,
    output issue_pkg::reg_addr_t                           rs1_o,
    input  issue_pkg::xlen_t                               rs1_i,
    input  logic                                           rs1_valid_i,
    output issue_pkg::reg_addr_t                           rs2_o,
    input  issue_pkg::xlen_t                               rs2_i,
    input  logic                                           rs2_valid_i,
    // unit readies
    input  logic                                           flu_ready_i,
    input  logic                                           lsu_ready_i,
    // write-back
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0]  commit_i,
    // toward execute
    output issue_pkg::fu_data_t                            fu_data_o,
    output logic                                           alu_valid_o,
    output logic                                           branch_valid_o,
    output logic                                           lsu_valid_o,
    output logic                                           csr_valid_o
);
    import issue_pkg::*;

    logic  forward_rs1;
    logic  forward_rs2;
    xlen_t rf_a;
    xlen_t rf_b;

    issue_hazard_check #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_hazard_check (
        .issue_instr_i ( issue_instr_i ),
        .issue_valid_i ( issue_valid_i ),
        .rd_clobber_i  ( rd_clobber_i  ),
        .rs1_valid_i   ( rs1_valid_i   ),
        .rs2_valid_i   ( rs2_valid_i   ),
        .flu_ready_i   ( flu_ready_i   ),
        .lsu_ready_i   ( lsu_ready_i   ),
        .commit_i      ( commit_i      ),
        .rs1_o         ( rs1_o         ),
        .rs2_o         ( rs2_o         ),
        .forward_rs1_o ( forward_rs1   ),
        .forward_rs2_o ( forward_rs2   ),
        .issue_ack_o   ( issue_ack_o   )
    );

    issue_regfile #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_regfile (
        .clk_i     ( clk_i             ),
        .rst_ni    ( rst_ni            ),
        .raddr_a_i ( issue_instr_i.rs1 ),
        .raddr_b_i ( issue_instr_i.rs2 ),
        .rdata_a_o ( rf_a              ),
        .rdata_b_o ( rf_b              ),
        .commit_i  ( commit_i          )
    );

    issue_operand_stage i_operand_stage (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .issue_instr_i  ( issue_instr_i  ),
        .issue_valid_i  ( issue_valid_i  ),
        .issue_ack_i    ( issue_ack_o    ),
        .flush_i        ( flush_i        ),
        .forward_rs1_i  ( forward_rs1    ),
        .forward_rs2_i  ( forward_rs2    ),
        .rs1_i          ( rs1_i          ),
        .rs2_i          ( rs2_i          ),
        .rf_a_i         ( rf_a           ),
        .rf_b_i         ( rf_b           ),
        .fu_data_o      ( fu_data_o      ),
        .alu_valid_o    ( alu_valid_o    ),
        .branch_valid_o ( branch_valid_o ),
        .lsu_valid_o    ( lsu_valid_o    ),
        .csr_valid_o    ( csr_valid_o    )
    );

endmodule

/* dv/tb_issue_read_operands.sv */
/*
 * Random testbench for the issue and read-operands stage, two commit ports.
 * Inputs change on the falling edge; ack is sampled 1 ns later.
 * Registered outputs are compared at the next falling edge.
 * fu_data_o is compared only in cycles where a unit valid is expected.
 */
module tb_issue_read_operands;
    timeunit 1ns;
    timeprecision 1ps;
    import issue_pkg::*;

    localparam int unsigned NR_COMMIT_PORTS = 2;
    localparam int unsigned NUM_CYCLES      = 2000;
    localparam int unsigned ACK_TIMEOUT     = 64;

    logic                                 clk_i;
    logic                                 rst_ni;
    logic                                 flush_i;
    issue_entry_t                         issue_instr_i;
    logic                                 issue_valid_i;
    logic                                 issue_ack_o;
    fu_t [NR_REGS-1:0]                    rd_clobber_i;
    reg_addr_t                            rs1_o;
    xlen_t                                rs1_i;
    logic                                 rs1_valid_i;
    reg_addr_t                            rs2_o;
    xlen_t                                rs2_i;
    logic                                 rs2_valid_i;
    logic                                 flu_ready_i;
    logic                                 lsu_ready_i;
    commit_port_t [NR_COMMIT_PORTS-1:0]   commit_i;
    fu_data_t                             fu_data_o;
    logic                                 alu_valid_o;
    logic                                 branch_valid_o;
    logic                                 lsu_valid_o;
    logic                                 csr_valid_o;

    // model state
    int unsigned lcg_state;
    int unsigned cycle_cnt;
    xlen_t       shadow_rf [NR_REGS];
    fu_data_t    exp_data;
    logic [3:0]  exp_valid;      // {csr, lsu, branch, alu}
    logic        idle_ack;

    issue_read_operands #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_dut (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .flush_i        ( flush_i        ),
        .issue_instr_i  ( issue_instr_i  ),
        .issue_valid_i  ( issue_valid_i  ),
        .issue_ack_o    ( issue_ack_o    ),
        .rd_clobber_i   ( rd_clobber_i   ),
        .rs1_o          ( rs1_o          ),
        .rs1_i          ( rs1_i          ),
        .rs1_valid_i    ( rs1_valid_i    ),
        .rs2_o          ( rs2_o          ),
        .rs2_i          ( rs2_i          ),
        .rs2_valid_i    ( rs2_valid_i    ),
        .flu_ready_i    ( flu_ready_i    ),
        .lsu_ready_i    ( lsu_ready_i    ),
        .commit_i       ( commit_i       ),
        .fu_data_o      ( fu_data_o      ),
        .alu_valid_o    ( alu_valid_o    ),
        .branch_valid_o ( branch_valid_o ),
        .lsu_valid_o    ( lsu_valid_o    ),
        .csr_valid_o    ( csr_valid_o    )
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // --------------------------------------------------------------------------
    // random numbers
    // --------------------------------------------------------------------------
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // low bits of an LCG are weak, use the upper ones
    function automatic int unsigned rand_below(input int unsigned n);
        return (lcg_next() >> 8) % n;
    endfunction

    // mostly x0..x7 so that hazards and commit hits collide often
    function automatic reg_addr_t pick_reg();
        if (rand_below(8) != 0) begin
            return reg_addr_t'(rand_below(8));
        end
        return reg_addr_t'(rand_below(NR_REGS));
    endfunction

    function automatic issue_entry_t build_entry();
        issue_entry_t e;
        e.fu       = fu_t'(rand_below(6));
        e.op       = fu_op_t'(rand_below(9));
        e.rs1      = pick_reg();
        e.rs2      = pick_reg();
        e.rd       = pick_reg();
        e.result   = lcg_next();
        e.use_imm  = rand_below(2) == 0;
        e.use_pc   = rand_below(8) == 0;
        e.use_zimm = rand_below(8) == 0;
        e.pc       = lcg_next() & 32'hffff_fffc;
        e.trans_id = TRANS_ID_BITS'(rand_below(8));
        e.ex_valid = rand_below(16) == 0;
        return e;
    endfunction

    // scoreboard, unit and commit side of one cycle
    task automatic randomize_env();
        for (int unsigned r = 0; r < NR_REGS; r++) begin
            // about one register in four is clobbered
            if (rand_below(4) == 0) begin
                rd_clobber_i[r] = fu_t'(1 + rand_below(5));
            end else begin
                rd_clobber_i[r] = NONE;
            end
        end
        rs1_i       = lcg_next();
        rs2_i       = lcg_next();
        rs1_valid_i = rand_below(4) != 0;
        rs2_valid_i = rand_below(4) != 0;
        flu_ready_i = rand_below(8) != 0;
        lsu_ready_i = rand_below(8) != 0;
        flush_i     = rand_below(16) == 0;
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            commit_i[p].we    = rand_below(2) == 0;
            commit_i[p].waddr = pick_reg();
            commit_i[p].wdata = lcg_next();
        end
        // commit never writes one nonzero register from both ports
        if (commit_i[0].we && commit_i[1].we && commit_i[0].waddr == commit_i[1].waddr &&
            commit_i[0].waddr != '0) begin
            commit_i[1].waddr = commit_i[1].waddr ^ 5'd1;
        end
    endtask

    // --------------------------------------------------------------------------
    // reference model
    // --------------------------------------------------------------------------
    function automatic xlen_t read_shadow(input reg_addr_t r);
        return (r == '0) ? '0 : shadow_rf[r];
    endfunction

    function automatic logic clobbered(input reg_addr_t r);
        return rd_clobber_i[r] != NONE;
    endfunction

    // forward only a ready value from a unit other than CSR
    function automatic logic forwards_rs1();
        return !issue_instr_i.use_zimm && clobbered(issue_instr_i.rs1) && rs1_valid_i &&
               rd_clobber_i[issue_instr_i.rs1] != CSR;
    endfunction

    function automatic logic forwards_rs2();
        return clobbered(issue_instr_i.rs2) && rs2_valid_i &&
               rd_clobber_i[issue_instr_i.rs2] != CSR;
    endfunction

    function automatic logic expected_ack();
        logic stall;
        logic busy;
        logic rd_free;
        stall = (!issue_instr_i.use_zimm && clobbered(issue_instr_i.rs1) && !forwards_rs1()) ||
                (clobbered(issue_instr_i.rs2) && !forwards_rs2());
        case (issue_instr_i.fu)
            ALU, CTRL_FLOW, CSR: busy = !flu_ready_i;
            LOAD, STORE:         busy = !lsu_ready_i;
            default:             busy = 1'b0;
        endcase
        rd_free = !clobbered(issue_instr_i.rd);
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && commit_i[p].waddr == issue_instr_i.rd) begin
                rd_free = 1'b1;
            end
        end
        if (!issue_valid_i) begin
            return 1'b0;
        end
        return issue_instr_i.ex_valid || issue_instr_i.fu == NONE ||
               (!stall && !busy && rd_free);
    endfunction

    // what the ID/EX register holds after the coming edge
    task automatic predict_outputs(input logic acked);
        logic issued;
        issued = acked && !issue_instr_i.ex_valid && !flush_i;
        exp_valid[0] = issued && issue_instr_i.fu == ALU;
        exp_valid[1] = issued && issue_instr_i.fu == CTRL_FLOW;
        exp_valid[2] = issued && (issue_instr_i.fu == LOAD || issue_instr_i.fu == STORE);
        exp_valid[3] = issued && issue_instr_i.fu == CSR;
        exp_data.fu       = issue_instr_i.fu;
        exp_data.op       = issue_instr_i.op;
        exp_data.imm      = issue_instr_i.result;
        exp_data.trans_id = issue_instr_i.trans_id;
        // operand a, lowest priority first
        exp_data.operand_a = read_shadow(issue_instr_i.rs1);
        if (forwards_rs1()) exp_data.operand_a = rs1_i;
        if (issue_instr_i.use_pc) exp_data.operand_a = issue_instr_i.pc;
        if (issue_instr_i.use_zimm) exp_data.operand_a = xlen_t'(issue_instr_i.rs1);
        // operand b
        exp_data.operand_b = read_shadow(issue_instr_i.rs2);
        if (forwards_rs2()) exp_data.operand_b = rs2_i;
        if (issue_instr_i.use_imm && issue_instr_i.fu != STORE &&
            issue_instr_i.fu != CTRL_FLOW) begin
            exp_data.operand_b = issue_instr_i.result;
        end
    endtask

    // commits land at the edge, the later port wins
    task automatic commit_shadow();
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && commit_i[p].waddr != '0) begin
                shadow_rf[commit_i[p].waddr] = commit_i[p].wdata;
            end
        end
    endtask

    // --------------------------------------------------------------------------
    // checks
    // --------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h (cycle %0d)",
                     name, got, exp, cycle_cnt);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_outputs();
        check_value("alu_valid_o", 32'(alu_valid_o), 32'(exp_valid[0]));
        check_value("branch_valid_o", 32'(branch_valid_o), 32'(exp_valid[1]));
        check_value("lsu_valid_o", 32'(lsu_valid_o), 32'(exp_valid[2]));
        check_value("csr_valid_o", 32'(csr_valid_o), 32'(exp_valid[3]));
        if (exp_valid != '0) begin
            check_value("fu_data_o.fu", 32'(fu_data_o.fu), 32'(exp_data.fu));
            check_value("fu_data_o.op", 32'(fu_data_o.op), 32'(exp_data.op));
            check_value("fu_data_o.operand_a", fu_data_o.operand_a, exp_data.operand_a);
            check_value("fu_data_o.operand_b", fu_data_o.operand_b, exp_data.operand_b);
            check_value("fu_data_o.imm", fu_data_o.imm, exp_data.imm);
            check_value("fu_data_o.trans_id", 32'(fu_data_o.trans_id),
                        32'(exp_data.trans_id));
        end
    endtask

    // one clock cycle: check last edge, drive, check ack, predict
    task automatic run_cycle(input logic valid, input issue_entry_t entry,
                             output logic acked);
        @(negedge clk_i);
        check_outputs();
        issue_valid_i = valid;
        issue_instr_i = entry;
        randomize_env();
        #1;
        acked = expected_ack();
        check_value("issue_ack_o", 32'(issue_ack_o), 32'(acked));
        check_value("rs1_o", 32'(rs1_o), 32'(entry.rs1));
        check_value("rs2_o", 32'(rs2_o), 32'(entry.rs2));
        predict_outputs(acked);
        commit_shadow();
        cycle_cnt++;
    endtask

    // producer holds the entry until it is acknowledged
    task automatic send_entry(input issue_entry_t entry);
        logic        acked;
        int unsigned waited;
        acked  = 1'b0;
        waited = 0;
        while (!acked) begin
            if (waited == ACK_TIMEOUT) begin
                $display("Timeout: entry with trans_id %0d not acknowledged in %0d cycles",
                         entry.trans_id, ACK_TIMEOUT);
                $display("CHECKS FAILED");
                $fatal(1, "acknowledge never came");
            end else begin
                run_cycle(1'b1, entry, acked);
                waited++;
            end
        end
    endtask

    // --------------------------------------------------------------------------
    // main sequence
    // --------------------------------------------------------------------------
    initial begin
        lcg_state     = 31319;
        cycle_cnt     = 0;
        rst_ni        = 1'b0;
        flush_i       = 1'b0;
        issue_instr_i = '0;
        issue_valid_i = 1'b0;
        rs1_i         = '0;
        rs2_i         = '0;
        rs1_valid_i   = 1'b0;
        rs2_valid_i   = 1'b0;
        flu_ready_i   = 1'b1;
        lsu_ready_i   = 1'b1;
        commit_i      = '0;
        for (int unsigned r = 0; r < NR_REGS; r++) begin
            rd_clobber_i[r] = NONE;
            shadow_rf[r]    = '0;
        end
        exp_data  = '0;
        exp_valid = '0;

        repeat (8) @(negedge clk_i);
        // reset values: no valid, zero data with fu NONE
        check_value("alu_valid_o", 32'(alu_valid_o), 32'd0);
        check_value("branch_valid_o", 32'(branch_valid_o), 32'd0);
        check_value("lsu_valid_o", 32'(lsu_valid_o), 32'd0);
        check_value("csr_valid_o", 32'(csr_valid_o), 32'd0);
        check_value("fu_data_o.fu", 32'(fu_data_o.fu), 32'(NONE));
        check_value("fu_data_o.op", 32'(fu_data_o.op), 32'd0);
        check_value("fu_data_o.operand_a", fu_data_o.operand_a, 32'd0);
        check_value("fu_data_o.operand_b", fu_data_o.operand_b, 32'd0);
        check_value("fu_data_o.imm", fu_data_o.imm, 32'd0);
        check_value("fu_data_o.trans_id", 32'(fu_data_o.trans_id), 32'd0);
        rst_ni = 1'b1;

        while (cycle_cnt < NUM_CYCLES) begin
            // now and then a bubble with a random but invalid entry
            if (rand_below(5) == 0) begin
                run_cycle(1'b0, build_entry(), idle_ack);
            end else begin
                send_entry(build_entry());
            end
        end
        // registered result of the last cycle
        @(negedge clk_i);
        check_outputs();

        $display("ALL CHECKS PASSED");
        $finish;
    end

    // backstop in case the clock stops advancing the sequence
    initial begin
        #1ms;
        $display("Timeout: simulation did not finish within its time limit");
        $display("CHECKS FAILED");
        $fatal(1, "simulation time limit reached");
    end

endmodule

/* issue_stage.f */
hw/issue_pkg.sv
hw/issue_hazard_check.sv
hw/issue_regfile.sv
hw/issue_operand_stage.sv
hw/issue_read_operands.sv
dv/tb_issue_read_operands.sv

/* run_sim.sh */
#!/bin/sh
# compile the issue stage testbench with Verilator and run it
# the exit status of the simulation binary is the test result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module tb_issue_read_operands \
    -Mdir build/obj_dir \
    -f issue_stage.f
./build/obj_dir/Vtb_issue_read_operands
